// File: source/holdGenPkg.sv
`default_nettype none

package holdGenPkg;

  // counter widths of the two delay timers
  localparam int HoldDelayWidth = 9;   // up to 511 cycles
  localparam int RazDelayWidth  = 10;  // up to 1023 cycles

  // hold trigger source, the three discriminators or the SMA input
  typedef enum logic [1:0] {
    trigDisc0    = 2'd0,
    trigDisc1    = 2'd1,
    trigDisc2    = 2'd2,
    trigExternal = 2'd3
  } trigSelT;

  // payload when regSel is 0
  typedef struct packed {
    logic                      holdEn;
    trigSelT                   trigSel;
    logic [HoldDelayWidth-1:0] holdDelay;
    logic [1:0]                pad;
  } holdFieldsT;

  // payload when regSel is 1
  typedef struct packed {
    logic                     razEn;
    logic [RazDelayWidth-1:0] razDelay;
    logic [2:0]               pad;
  } razFieldsT;

  // same 14 bits, read two ways depending on regSel
  typedef union packed {
    holdFieldsT hold;
    razFieldsT  raz;
  } cfgPayloadU;

  typedef struct packed {
    logic       regSel;   // 0 hold, 1 raz
    cfgPayloadU payload;
  } cfgWordT;

  // one record per accepted hold
  typedef struct packed {
    logic [7:0] eventSeq;  // wraps
    trigSelT    trigSrc;
    logic       lost;      // an older record was overwritten
    logic       spare;
  } eventRecT;

endpackage

`default_nettype wire

// File: source/trigSync.sv
`timescale 1ns/10ps
`default_nettype none

module trigSync
  import holdGenPkg::*;
(
  input  wire logic    Clk,
  input  wire logic    reset_n,
  input  wire logic    trig0B,    // active low, async
  input  wire logic    trig1B,
  input  wire logic    trig2B,
  input  wire logic    extTrigB,
  input  wire trigSelT trigSel,
  output logic         selFall,   // one cycle per falling edge of the selected trigger
  output logic         allFall    // one cycle when any discriminator falls
);

  logic       selRaw;
  logic       allRaw;
  logic [1:0] selSync;  // [0] first stage
  logic [1:0] allSync;

  always_comb begin
    case (trigSel)
      trigDisc0: selRaw = trig0B;
      trigDisc1: selRaw = trig1B;
      trigDisc2: selRaw = trig2B;
      default:   selRaw = extTrigB;
    endcase
  end

  // low as soon as one discriminator fires
  assign allRaw = trig0B & trig1B & trig2B;

  // both chains idle high
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      selSync <= 2'b11;
      allSync <= 2'b11;
    end else begin
      selSync <= {selSync[0], selRaw};
      allSync <= {allSync[0], allRaw};
    end
  end

  // old value high, new value low
  assign selFall = selSync[1] & ~selSync[0];
  assign allFall = allSync[1] & ~allSync[0];

endmodule

`default_nettype wire

// File: source/delayPulse.sv
`timescale 1ns/10ps
`default_nettype none

module delayPulse #(
  parameter int DelayWidth = 9,
  parameter int PulseWidth = 3200
) (
  input  wire logic                  Clk,
  input  wire logic                  reset_n,
  input  wire logic                  start,
  input  wire logic [DelayWidth-1:0] delay,
  output logic                       pulse,
  output logic                       busy
);

  // one counter serves both phases, sized for the longer one
  localparam int PulseCntWidth = $clog2(PulseWidth + 1);
  localparam int CntWidth = (DelayWidth > PulseCntWidth) ? DelayWidth : PulseCntWidth;

  typedef enum logic [1:0] {
    idle     = 2'd0,
    counting = 2'd1,
    pulsing  = 2'd2
  } stateT;

  stateT               state;
  logic [CntWidth-1:0] cnt;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= idle;
      cnt   <= '0;
      pulse <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (start)
            state <= counting;
        end
        counting: begin
          if (cnt < CntWidth'(delay)) begin
            cnt <= cnt + 1'b1;
          end else begin
            cnt   <= '0;
            pulse <= 1'b1;  // rises delay+1 edges after start
            state <= pulsing;
          end
        end
        pulsing: begin
          if (cnt < CntWidth'(PulseWidth)) begin
            cnt <= cnt + 1'b1;
          end else begin
            // high for PulseWidth+1 cycles in total
            cnt   <= '0;
            pulse <= 1'b0;
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  assign busy = (state != idle);

  // the controller must hold off starts while a pulse runs
  startWhileBusy: assert property (
    @(posedge Clk) disable iff (!reset_n) start |-> !busy
  ) else $error("delayPulse start while busy");

endmodule

`default_nettype wire

// File: source/holdControl.sv
`timescale 1ns/10ps
`default_nettype none

module holdControl
  import holdGenPkg::*;
(
  input  wire logic                      Clk,
  input  wire logic                      reset_n,
  input  wire logic                      cfgValid,
  input  wire cfgWordT                   cfgWord,
  input  wire logic                      selFall,
  input  wire logic                      allFall,
  input  wire logic                      holdBusy,
  input  wire logic                      razBusy,
  input  wire logic                      evReady,
  output logic                           cfgReady,
  output trigSelT                        trigSel,
  output logic      [HoldDelayWidth-1:0] holdDelay,
  output logic      [RazDelayWidth-1:0]  razDelay,
  output logic                           holdStart,
  output logic                           razStart,
  output logic                           evValid,
  output eventRecT                       evRec
);

  logic       holdEn;
  logic       razEn;
  logic       cfgXfer;
  logic [7:0] seqCnt;     // next eventSeq to hand out
  logic       overwrite;  // pending record about to be replaced

  // no config change while a timer runs or is being started
  assign cfgReady = ~(holdBusy | razBusy | holdStart | razStart);
  assign cfgXfer  = cfgValid & cfgReady;

  // edges are dropped while disabled or busy
  assign holdStart = selFall & holdEn & ~holdBusy;
  assign razStart  = allFall & razEn & ~razBusy;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      holdEn    <= 1'b0;
      razEn     <= 1'b0;
      trigSel   <= trigDisc0;
      holdDelay <= '0;
      razDelay  <= '0;
    end else if (cfgXfer) begin
      if (!cfgWord.regSel) begin
        // hold view of the payload
        holdEn    <= cfgWord.payload.hold.holdEn;
        trigSel   <= cfgWord.payload.hold.trigSel;
        holdDelay <= cfgWord.payload.hold.holdDelay;
      end else begin
        razEn    <= cfgWord.payload.raz.razEn;
        razDelay <= cfgWord.payload.raz.razDelay;
      end
    end
  end

  assign overwrite = evValid & ~evReady;

  // valid rises with the edge that samples holdStart
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      evValid <= 1'b0;
      seqCnt  <= '0;
    end else begin
      if (holdStart) begin
        evValid <= 1'b1;
        seqCnt  <= seqCnt + 1'b1;
      end else if (evReady) begin
        evValid <= 1'b0;
      end
    end
  end

  // a new hold always replaces a stalled record
  always_ff @(posedge Clk) begin
    if (holdStart) begin
      evRec.eventSeq <= seqCnt;
      evRec.trigSrc  <= trigSel;
      evRec.lost     <= overwrite;
      evRec.spare    <= 1'b0;
    end
  end

  // only an overwrite may change a stalled record, and it carries lost and the next number
  recStable: assert property (
    @(posedge Clk) disable iff (!reset_n)
    (evValid && !evReady) |=>
      ($stable(evRec) ||
       (evRec.lost && (evRec.eventSeq == $past(evRec.eventSeq) + 8'd1)))
  ) else $error("event record changed while stalled");

  noCfgAtStart: assert property (
    @(posedge Clk) disable iff (!reset_n) !(holdStart && cfgXfer)
  ) else $error("config accepted together with hold start");

endmodule

`default_nettype wire

// File: source/holdGenTop.sv
`timescale 1ns/10ps
`default_nettype none

module holdGenTop
  import holdGenPkg::*;
#(
  parameter int HoldWidth = 3200,  // hold length in cycles, minus one
  parameter int RazWidth  = 16
) (
  input  wire logic    Clk,
  input  wire logic    reset_n,
  input  wire logic    trig0B,
  input  wire logic    trig1B,
  input  wire logic    trig2B,
  input  wire logic    extTrigB,
  input  wire logic    cfgValid,
  input  wire cfgWordT cfgWord,
  output logic         cfgReady,
  output logic         evValid,
  output eventRecT     evRec,
  input  wire logic    evReady,
  output logic         hold,
  output logic         singleRazEn
);

  trigSelT                   trigSel;
  logic                      selFall;
  logic                      allFall;
  logic                      holdStart;
  logic                      razStart;
  logic                      holdBusy;
  logic                      razBusy;
  logic [HoldDelayWidth-1:0] holdDelay;
  logic [RazDelayWidth-1:0]  razDelay;

  trigSync trigSync_i (
    .Clk      (Clk),
    .reset_n  (reset_n),
    .trig0B   (trig0B),
    .trig1B   (trig1B),
    .trig2B   (trig2B),
    .extTrigB (extTrigB),
    .trigSel  (trigSel),
    .selFall  (selFall),
    .allFall  (allFall)
  );

  holdControl holdControl_i (
    .Clk       (Clk),
    .reset_n   (reset_n),
    .cfgValid  (cfgValid),
    .cfgWord   (cfgWord),
    .selFall   (selFall),
    .allFall   (allFall),
    .holdBusy  (holdBusy),
    .razBusy   (razBusy),
    .evReady   (evReady),
    .cfgReady  (cfgReady),
    .trigSel   (trigSel),
    .holdDelay (holdDelay),
    .razDelay  (razDelay),
    .holdStart (holdStart),
    .razStart  (razStart),
    .evValid   (evValid),
    .evRec     (evRec)
  );

  // freezes the analogue sample
  delayPulse #(
    .DelayWidth (HoldDelayWidth),
    .PulseWidth (HoldWidth)
  ) holdTimer_i (
    .Clk     (Clk),
    .reset_n (reset_n),
    .start   (holdStart),
    .delay   (holdDelay),
    .pulse   (hold),
    .busy    (holdBusy)
  );

  delayPulse #(
    .DelayWidth (RazDelayWidth),
    .PulseWidth (RazWidth)
  ) razTimer_i (
    .Clk     (Clk),
    .reset_n (reset_n),
    .start   (razStart),
    .delay   (razDelay),
    .pulse   (singleRazEn),
    .busy    (razBusy)
  );

endmodule

`default_nettype wire

// File: testbench/holdGenTb.sv
`timescale 1ns/10ps
`default_nettype none

module holdGenTb
  import holdGenPkg::*;
();

  localparam int HoldLen  = 40;
  localparam int RazLen   = 16;
  localparam int MaxDelay = 63;  // random delays take 6 bits
  localparam int Test1Len = 40;
  localparam int Test2Len = 4 * (2 * MaxDelay + HoldLen + 40);
  localparam int Test3Len = 2 * MaxDelay + HoldLen + 60;
  localparam int Test4Len = 5 * (MaxDelay + RazLen + 20) + 20;
  localparam int Test5Len = 2 * (MaxDelay + HoldLen + 30) + 30;
  localparam int CycleLimit =
    3 * (16 + Test1Len + Test2Len + Test3Len + Test4Len + Test5Len) / 2;

  logic        Clk      = 1'b0;
  logic        reset_n  = 1'b0;
  logic        trig0B   = 1'b1;
  logic        trig1B   = 1'b1;
  logic        trig2B   = 1'b1;
  logic        extTrigB = 1'b1;
  logic        cfgValid = 1'b0;
  cfgWordT     cfgWord  = '0;
  logic        evReady  = 1'b0;
  logic        cfgReady;
  logic        evValid;
  eventRecT    evRec;
  logic        hold;
  logic        singleRazEn;
  int          cycleCount  = 0;
  int          valueErrors = 0;
  int          otherErrors = 0;
  logic [7:0]  expSeq      = 8'd0;  // next eventSeq expected
  logic [31:0] lfsrState   = 32'h8666_7c54;

  holdGenTop #(.HoldWidth(HoldLen), .RazWidth(RazLen)) holdGenTop_i (
    .Clk(Clk), .reset_n(reset_n), .trig0B(trig0B), .trig1B(trig1B), .trig2B(trig2B),
    .extTrigB(extTrigB), .cfgValid(cfgValid), .cfgWord(cfgWord), .cfgReady(cfgReady),
    .evValid(evValid), .evRec(evRec), .evReady(evReady), .hold(hold),
    .singleRazEn(singleRazEn)
  );

  always #50 Clk = ~Clk;

  always @(posedge Clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("timeout: tests did not finish within %0d cycles", CycleLimit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic takeBits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      val = {val[30:0], lfsrState[0]};
    end
  endtask

  function automatic cfgWordT holdWord(input logic en, input trigSelT sel,
                                       input logic [HoldDelayWidth-1:0] dly);
    cfgWordT w;
    w = '0;
    w.payload.hold.holdEn    = en;
    w.payload.hold.trigSel   = sel;
    w.payload.hold.holdDelay = dly;
    return w;
  endfunction

  function automatic cfgWordT razWord(input logic en, input logic [RazDelayWidth-1:0] dly);
    cfgWordT w;
    w = '0;
    w.regSel               = 1'b1;
    w.payload.raz.razEn    = en;
    w.payload.raz.razDelay = dly;
    return w;
  endfunction

  task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      valueErrors++;
      $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic idleCycles(input int n);
    repeat (n) @(posedge Clk);
  endtask

  // bit 0 disc0 up to bit 3 external
  task automatic driveTrigs(input logic [3:0] lvl);
    @(posedge Clk);
    {extTrigB, trig2B, trig1B, trig0B} <= lvl;
  endtask

  task automatic writeCfg(input cfgWordT w);
    int waitCnt;
    waitCnt = 0;
    @(negedge Clk);
    while (!cfgReady && waitCnt < 200) begin
      @(negedge Clk);
      waitCnt++;
    end
    if (!cfgReady) begin
      otherErrors++;
      $display("%0t: config port never became ready", $time);
    end
    @(posedge Clk);
    cfgValid <= 1'b1;
    cfgWord  <= w;
    @(posedge Clk);  // transfer edge
    cfgValid <= 1'b0;
  endtask

  // counts edges until the output is seen at the given level
  task automatic countToLevel(input logic useRaz, input logic level, input int limit,
                              output int cycles);
    logic  seen;
    string sig;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < limit) begin
      @(posedge Clk);
      cycles++;
      @(negedge Clk);
      seen = useRaz ? (singleRazEn === level) : (hold === level);
    end
    if (!seen) begin
      if (useRaz) sig = "singleRazEn";
      else sig = "hold";
      otherErrors++;
      $display("%0t: %s did not go to %0b within %0d cycles", $time, sig, level, limit);
    end
  endtask

  task automatic watchQuiet(input int n, input logic checkEv);
    repeat (n) begin
      @(negedge Clk);
      checkVal("hold", 0, 32'(hold));
      checkVal("singleRazEn", 0, 32'(singleRazEn));
      if (checkEv) checkVal("evValid", 0, 32'(evValid));
    end
  endtask

  task automatic checkEvent(input logic [7:0] seq, input trigSelT src, input logic lost);
    @(negedge Clk);
    checkVal("evValid", 1, 32'(evValid));
    checkVal("evRec.eventSeq", 32'(seq), 32'(evRec.eventSeq));
    checkVal("evRec.trigSrc", 32'(src), 32'(evRec.trigSrc));
    checkVal("evRec.lost", 32'(lost), 32'(evRec.lost));
    checkVal("evRec.spare", 0, 32'(evRec.spare));
  endtask

  task automatic acceptEvent();
    @(posedge Clk);
    evReady <= 1'b1;
    @(posedge Clk);
    evReady <= 1'b0;
    @(negedge Clk);
    checkVal("evValid", 0, 32'(evValid));
  endtask

  // rise is delay+3 edges after the drive edge, one of them in the synchronizer
  task automatic runHold(input trigSelT src, input logic [31:0] dly);
    int c;
    driveTrigs(~(4'b0001 << src));
    countToLevel(1'b0, 1'b1, dly + 10, c);
    checkVal("hold rise cycle", dly + 3, 32'(c));
    countToLevel(1'b0, 1'b0, HoldLen + 5, c);
    checkVal("hold high cycles", HoldLen + 1, 32'(c));
  endtask

  task automatic testReset();
    @(negedge Clk);
    checkVal("hold", 0, 32'(hold));
    checkVal("singleRazEn", 0, 32'(singleRazEn));
    checkVal("evValid", 0, 32'(evValid));
    checkVal("cfgReady", 1, 32'(cfgReady));
    driveTrigs(4'b1110);  // holdEn still clear
    watchQuiet(20, 1'b1);
    driveTrigs(4'hF);
    idleCycles(4);
  endtask

  task automatic testHoldPerSource();
    trigSelT     sel;
    logic [31:0] dly;
    for (int s = 0; s < 4; s++) begin
      sel = trigSelT'(s[1:0]);
      takeBits(6, dly);
      writeCfg(holdWord(1'b1, sel, dly[8:0]));
      driveTrigs(4'b0001 << sel);  // all other sources fall
      watchQuiet(dly + 6, 1'b1);
      driveTrigs(4'hF);
      idleCycles(4);
      runHold(sel, dly);
      checkEvent(expSeq, sel, 1'b0);
      driveTrigs(4'hF);
      acceptEvent();
      expSeq = expSeq + 8'd1;
      idleCycles(3);
    end
  endtask

  task automatic testRetrigger();
    trigSelT     src;
    logic [31:0] rnd;
    logic [31:0] dly;
    int          c;
    takeBits(2, rnd);
    src = trigSelT'(rnd[1:0]);
    takeBits(6, dly);
    writeCfg(holdWord(1'b1, src, dly[8:0]));
    driveTrigs(~(4'b0001 << src));
    countToLevel(1'b0, 1'b1, dly + 10, c);
    checkVal("hold rise cycle", dly + 3, 32'(c));
    checkVal("cfgReady", 0, 32'(cfgReady));
    driveTrigs(4'hF);
    idleCycles(1);
    driveTrigs(~(4'b0001 << src));  // second edge during the pulse
    countToLevel(1'b0, 1'b0, HoldLen + 5, c);
    checkVal("hold high cycles", HoldLen + 1, 32'(c + 3));
    watchQuiet(dly + 10, 1'b0);
    checkEvent(expSeq, src, 1'b0);
    driveTrigs(4'hF);
    acceptEvent();
    expSeq = expSeq + 8'd1;
    idleCycles(3);
  endtask

  task automatic testRaz();
    logic [31:0] rd;
    int          c;
    writeCfg(holdWord(1'b0, trigDisc0, 9'd0));
    takeBits(6, rd);
    writeCfg(razWord(1'b1, rd[9:0]));
    for (int d = 0; d < 3; d++) begin
      driveTrigs(~(4'b0001 << d));
      countToLevel(1'b1, 1'b1, rd + 10, c);
      checkVal("singleRazEn rise cycle", rd + 3, 32'(c));
      countToLevel(1'b1, 1'b0, RazLen + 5, c);
      checkVal("singleRazEn high cycles", RazLen + 1, 32'(c));
      driveTrigs(4'hF);
      idleCycles(4);
    end
    driveTrigs(4'b0111);  // external alone
    watchQuiet(rd + RazLen + 6, 1'b1);
    driveTrigs(4'hF);
    idleCycles(4);
    writeCfg(razWord(1'b0, rd[9:0]));
    driveTrigs(4'b1110);
    watchQuiet(rd + RazLen + 6, 1'b1);
    driveTrigs(4'hF);
    idleCycles(4);
  endtask

  task automatic testLostRecord();
    trigSelT     src;
    logic [31:0] rnd;
    logic [31:0] dly;
    for (int k = 0; k < 2; k++) begin
      takeBits(2, rnd);
      src = trigSelT'(rnd[1:0]);
      takeBits(6, dly);
      writeCfg(holdWord(1'b1, src, dly[8:0]));
      runHold(src, dly);
      checkEvent(expSeq + 8'(k), src, k[0]);
      driveTrigs(4'hF);
      idleCycles(4);
    end
    // second record stays put while stalled
    for (int i = 0; i < 8; i++) checkEvent(expSeq + 8'd1, src, 1'b1);
    acceptEvent();
    expSeq = expSeq + 8'd2;
  endtask

  initial begin
    repeat (16) @(posedge Clk);
    reset_n <= 1'b1;
    idleCycles(2);
    testReset();
    testHoldPerSource();
    testRetrigger();
    testRaz();
    testLostRecord();
    idleCycles(2);
    $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: holdGen.f
source/holdGenPkg.sv
source/trigSync.sv
source/delayPulse.sv
source/holdControl.sv
source/holdGenTop.sv
testbench/holdGenTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= holdGenTb
LINT_TOP  ?= holdGenTop
FILELIST  ?= holdGen.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

# status comes from the pass line in the simulator output
run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
